// File: hazard_resolution.f
source/hazard_pkg.sv
source/load_use_detector.sv
source/execute_stall_unit.sv
source/mmio_load_guard.sv
source/flush_control.sv
source/valid_token_tracker.sv
source/hazard_resolution_unit.sv
tb/tb_hazard_resolution_unit.sv

// File: Makefile
TOP  := tb_hazard_resolution_unit
SRCS := $(wildcard source/*.sv) $(wildcard tb/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/V$(TOP): $(SRCS) hazard_resolution.f
	verilator --binary --timing --top-module $(TOP) -f hazard_resolution.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -qF '*** TEST FAILED ***' sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -qF '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb/tb_hazard_resolution_unit.sv
// Directed checks of the integer-only hazard unit; expects six stages and the fixed MMIO window
`default_nettype none

module tb_hazard_resolution_unit;

  logic                       clk;
  logic                       pipeline_reset;
  hazard_pkg::pd_sources_t    pd_sources;
  hazard_pkg::id_ex_info_t    id_ex;
  hazard_pkg::ex_ma_info_t    ex_ma;
  hazard_pkg::ex_comb_t       ex_comb;
  hazard_pkg::cache_status_t  cache;
  logic                       trap_taken;
  logic                       mret_taken;
  logic                       stall_for_wfi;

  hazard_pkg::pipeline_ctrl_t pipeline_ctrl;
  logic                       mmio_read_pulse;
  logic                       rst_done;
  logic                       vld;
  logic                       pc_vld;

  int          checks;
  int          errors;
  int          timeouts;
  int          wait_limit = 64;

  hazard_resolution_unit u_hazard_resolution_unit (
    .i_clk             (clk),
    .i_pipeline_reset  (pipeline_reset),
    .i_pd_sources      (pd_sources),
    .i_id_ex           (id_ex),
    .i_ex_ma           (ex_ma),
    .i_ex_comb         (ex_comb),
    .i_cache           (cache),
    .i_trap_taken      (trap_taken),
    .i_mret_taken      (mret_taken),
    .i_stall_for_wfi   (stall_for_wfi),
    .o_pipeline_ctrl   (pipeline_ctrl),
    .o_mmio_read_pulse (mmio_read_pulse),
    .o_rst_done        (rst_done),
    .o_vld             (vld),
    .o_pc_vld          (pc_vld)
  );

  // Inputs change just after the rising edge and outputs are read at the falling edge
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ==============================
  // Helpers
  // ==============================

  task automatic compare_values(input int actual, input int expected, input string what);
    checks++;
    if (actual != expected) begin
      errors++;
      $display("FAIL t=%0t: %s, got %0d, expected %0d", $time, what, actual, expected);
    end
  endtask

  task automatic note_timeout(input string what);
    timeouts++;
    $display("Timeout after %0d cycles while waiting for %s", wait_limit, what);
  endtask

  // Empty pipeline with no redirect and no stall request
  task automatic drive_idle();
    pd_sources <= '0;
    id_ex <= '0;
    ex_ma <= '0;
    ex_comb <= '0;
    cache <= '0;
    trap_taken <= 1'b0;
    mret_taken <= 1'b0;
    stall_for_wfi <= 1'b0;
  endtask

  // Returns on the edge where the DUT still sees reset for the last time
  task automatic apply_reset();
    @(posedge clk);
    drive_idle();
    pipeline_reset <= 1'b1;
    repeat (10) @(posedge clk);
    pipeline_reset <= 1'b0;
  endtask

  // ==============================
  // Directed tests
  // ==============================

  task automatic reset_behaviour();
    apply_reset();
    @(negedge clk);
    compare_values(int'(pipeline_ctrl.stall), 0, "stall after reset");
    compare_values(int'(pipeline_ctrl.flush), 0, "flush after reset");
    compare_values(int'(mmio_read_pulse), 0, "MMIO pulse after reset");
    compare_values(int'(vld), 0, "vld after reset");
    compare_values(int'(pc_vld), 0, "pc_vld after reset");
    // Cache tag clearing holds the whole pipeline in reset
    @(posedge clk);
    cache.reset_in_progress <= 1'b1;
    @(negedge clk);
    compare_values(int'(rst_done), 0, "rst_done while cache resets");
    compare_values(int'(pipeline_ctrl.reset), 1, "reset field while cache resets");
    @(posedge clk);
    cache.reset_in_progress <= 1'b0;
    @(negedge clk);
    compare_values(int'(rst_done), 1, "rst_done after cache reset");
    compare_values(int'(pipeline_ctrl.reset), 0, "reset field after cache reset");
  endtask

  // One load followed by its consumer, with four sampled cycles
  task automatic load_use_case(input hazard_pkg::reg_idx_t rd, input logic use_src2,
                               input logic hit, input string what);
    int stalls;
    int flags;
    int expected;
    stalls = 0;
    flags = 0;
    // A bubble is owed only for a real register that the cache misses on
    expected = (rd != '0 && !hit) ? 1 : 0;
    apply_reset();
    @(posedge clk);
    id_ex.is_load <= 1'b1;
    id_ex.dest_reg <= rd;
    if (use_src2) begin
      pd_sources.source_reg_2_early <= rd;
    end else begin
      pd_sources.source_reg_1_early <= rd;
    end
    cache.hit_on_load <= hit;
    @(negedge clk);
    stalls += int'(pipeline_ctrl.stall);
    @(posedge clk);
    // The load moves on to MA and its consumer reaches EX
    id_ex <= '0;
    pd_sources <= '0;
    ex_ma.is_load <= 1'b1;
    ex_ma.data_memory_address <= 32'h0000_1000;
    repeat (3) begin
      @(negedge clk);
      stalls += int'(pipeline_ctrl.stall);
      flags += int'(pipeline_ctrl.stall_for_load_use_hazard);
    end
    compare_values(stalls, expected, {what, " stall cycles"});
    compare_values(flags, expected, {what, " load-use flag cycles"});
  endtask

  task automatic load_use_bubbles();
    hazard_pkg::reg_idx_t rd;
    rd = hazard_pkg::reg_idx_t'(1 + ($urandom % 31));
    load_use_case(rd, 1'b0, 1'b0, "load-use miss");
    load_use_case(rd, 1'b1, 1'b0, "load-use miss on source 2");
    load_use_case(rd, 1'b1, 1'b1, "load-use hit");
    load_use_case('0, 1'b0, 1'b0, "load-use x0");
  endtask

  task automatic multiply_divide_stalls();
    int stalls;
    int raise_at;
    int busy_cycles;
    hazard_pkg::reg_idx_t rd;
    // The prediction rises just after stalled cycle raise_at, and the cycle it rises in still stalls
    raise_at = 3;
    stalls = 0;
    apply_reset();
    @(posedge clk);
    id_ex.is_multiply <= 1'b1;
    @(negedge clk);
    while (pipeline_ctrl.stall && stalls < wait_limit) begin
      stalls++;
      @(posedge clk);
      if (stalls == raise_at) begin
        ex_comb.multiply_completing_next_cycle <= 1'b1;
      end
      @(negedge clk);
    end
    if (stalls >= wait_limit) begin
      note_timeout("the multiply stall to end");
    end
    compare_values(stalls, raise_at + 1, "multiply stall cycles");

    // Divide latency is whatever the divider reports through busy
    busy_cycles = 2 + int'($urandom % 5);
    stalls = 0;
    apply_reset();
    @(posedge clk);
    id_ex.is_divide <= 1'b1;
    ex_comb.divide_busy <= 1'b1;
    @(negedge clk);
    while (pipeline_ctrl.stall && stalls < wait_limit) begin
      stalls++;
      @(posedge clk);
      if (stalls == busy_cycles) begin
        ex_comb.divide_busy <= 1'b0;
      end
      @(negedge clk);
    end
    if (stalls >= wait_limit) begin
      note_timeout("the divide stall to end");
    end
    compare_values(stalls, busy_cycles, "divide stall cycles");

    // A missed load hazard that lands while a divide already stalls
    rd = hazard_pkg::reg_idx_t'(1 + ($urandom % 31));
    apply_reset();
    @(posedge clk);
    id_ex.is_load <= 1'b1;
    id_ex.dest_reg <= rd;
    pd_sources.source_reg_1_early <= rd;
    @(posedge clk);
    id_ex.is_load <= 1'b0;
    id_ex.is_divide <= 1'b1;
    ex_comb.divide_busy <= 1'b1;
    pd_sources <= '0;
    ex_ma.is_load <= 1'b1;
    ex_ma.data_memory_address <= 32'h0000_2000;
    repeat (2) begin
      @(negedge clk);
      compare_values(int'(pipeline_ctrl.stall), 1, "stall during divide");
      compare_values(int'(pipeline_ctrl.load_use_hazard_detected), 1,
                     "raw load-use during divide");
      compare_values(int'(pipeline_ctrl.stall_for_load_use_hazard), 0,
                     "load-use stall under divide");
    end
  endtask

  task automatic csr_and_mmio_stalls();
    int stalls;
    int pulses;
    logic [31:0] offset;
    apply_reset();
    @(posedge clk);
    id_ex.is_csr <= 1'b1;
    @(negedge clk);
    compare_values(int'(pipeline_ctrl.stall), 1, "CSR first cycle stall");
    compare_values(int'(pipeline_ctrl.stall_for_trap_check), 0, "trap check during CSR wait");
    @(negedge clk);
    compare_values(int'(pipeline_ctrl.stall), 0, "CSR second cycle stall");

    // Word-aligned load somewhere inside the I/O window
    offset = ($urandom % 10) * 4;
    stalls = 0;
    pulses = 0;
    @(posedge clk);
    id_ex.is_csr <= 1'b0;
    ex_ma.is_load <= 1'b1;
    ex_ma.data_memory_address <= hazard_pkg::MMIO_BASE_ADDR + offset;
    @(negedge clk);
    pulses += int'(mmio_read_pulse);
    while (pipeline_ctrl.stall && stalls < wait_limit) begin
      stalls++;
      @(negedge clk);
      pulses += int'(mmio_read_pulse);
    end
    if (stalls >= wait_limit) begin
      note_timeout("the MMIO stall to end");
    end
    compare_values(stalls, int'(hazard_pkg::MMIO_STALL_CYCLES), "MMIO stall cycles");
    compare_values(pulses, 1, "MMIO read pulses");

    // The end address is the first byte outside the window
    stalls = 0;
    pulses = 0;
    @(posedge clk);
    ex_ma.data_memory_address <= hazard_pkg::MMIO_BASE_ADDR + hazard_pkg::MMIO_SIZE_BYTES;
    repeat (2) begin
      @(negedge clk);
      stalls += int'(pipeline_ctrl.stall);
      pulses += int'(mmio_read_pulse);
    end
    compare_values(stalls, 0, "stalls outside MMIO window");
    compare_values(pulses, 0, "pulses outside MMIO window");
  endtask

  task automatic redirect_flushes();
    int flushes;
    flushes = 0;
    apply_reset();
    @(posedge clk);
    ex_comb.branch_taken <= 1'b1;
    @(negedge clk);
    while (pipeline_ctrl.flush && flushes < wait_limit) begin
      flushes++;
      @(posedge clk);
      ex_comb.branch_taken <= 1'b0;
      @(negedge clk);
    end
    if (flushes >= wait_limit) begin
      note_timeout("the branch flush to end");
    end
    compare_values(flushes, 2, "taken branch flush cycles");

    // WFI holds until a trap breaks it
    @(posedge clk);
    stall_for_wfi <= 1'b1;
    repeat (3) begin
      @(negedge clk);
      compare_values(int'(pipeline_ctrl.stall), 1, "stall during WFI");
      compare_values(int'(pipeline_ctrl.flush), 0, "flush during WFI");
    end
    @(posedge clk);
    trap_taken <= 1'b1;
    @(negedge clk);
    compare_values(int'(pipeline_ctrl.stall), 0, "stall in trap cycle");
    compare_values(int'(pipeline_ctrl.flush), 1, "flush in trap cycle");
    // The trap unit still sees WFI because its level ignores the trap itself
    compare_values(int'(pipeline_ctrl.stall_for_trap_check), 1,
                   "trap check level in trap cycle");
    compare_values(int'(pipeline_ctrl.stall_registered), 1,
                   "registered stall in trap cycle");
    @(posedge clk);
    trap_taken <= 1'b0;
    stall_for_wfi <= 1'b0;
    @(negedge clk);
    compare_values(int'(pipeline_ctrl.flush), 1, "flush after trap");
    compare_values(int'(pipeline_ctrl.trap_taken_registered), 1, "registered trap");
    compare_values(int'(pipeline_ctrl.stall_registered), 0, "registered stall after trap");
    @(negedge clk);
    compare_values(int'(pipeline_ctrl.flush), 0, "flush two cycles after trap");

    // A stall right after a branch drops the second flush cycle for good
    @(posedge clk);
    ex_comb.branch_taken <= 1'b1;
    @(negedge clk);
    compare_values(int'(pipeline_ctrl.flush), 1, "flush on branch before stall");
    @(posedge clk);
    ex_comb.branch_taken <= 1'b0;
    stall_for_wfi <= 1'b1;
    @(negedge clk);
    compare_values(int'(pipeline_ctrl.flush), 0, "flush masked by stall");
    @(posedge clk);
    stall_for_wfi <= 1'b0;
    @(negedge clk);
    compare_values(int'(pipeline_ctrl.stall), 0, "stall released");
    compare_values(int'(pipeline_ctrl.flush), 0, "late flush after stall");

    // MRET also wakes a WFI and redirects like a trap
    @(posedge clk);
    stall_for_wfi <= 1'b1;
    mret_taken <= 1'b1;
    @(negedge clk);
    compare_values(int'(pipeline_ctrl.stall), 0, "stall in MRET cycle");
    compare_values(int'(pipeline_ctrl.flush), 1, "flush in MRET cycle");
    @(posedge clk);
    mret_taken <= 1'b0;
    stall_for_wfi <= 1'b0;
    @(negedge clk);
    compare_values(int'(pipeline_ctrl.flush), 1, "flush after MRET");
    compare_values(int'(pipeline_ctrl.mret_taken_registered), 1, "registered MRET");
    @(negedge clk);
    compare_values(int'(pipeline_ctrl.flush), 0, "flush two cycles after MRET");
  endtask

  task automatic valid_strobe_timing();
    int n;
    int first_pc;
    int first_vld;
    n = 0;
    first_pc = -1;
    first_vld = -1;
    apply_reset();
    // Cycle n has seen n free-running edges since reset
    while ((first_pc < 0 || first_vld < 0) && n < wait_limit) begin
      @(negedge clk);
      if (first_pc < 0 && pc_vld) begin
        first_pc = n;
      end
      if (first_vld < 0 && vld) begin
        first_vld = n;
      end
      n++;
    end
    if (n >= wait_limit) begin
      note_timeout("the valid strobes to rise");
    end
    compare_values(first_pc, int'(hazard_pkg::PC_VALID_STAGE_INDEX) + 1, "first pc_vld cycle");
    compare_values(first_vld, int'(hazard_pkg::NUM_PIPELINE_STAGES), "first vld cycle");
    @(posedge clk);
    stall_for_wfi <= 1'b1;
    repeat (2) begin
      @(negedge clk);
      compare_values(int'(vld), 0, "vld while stalled");
      compare_values(int'(pc_vld), 0, "pc_vld while stalled");
    end
    @(posedge clk);
    stall_for_wfi <= 1'b0;
    @(negedge clk);
    compare_values(int'(vld), 1, "vld after stall");
    compare_values(int'(pc_vld), 1, "pc_vld after stall");
  endtask

  // ==============================
  // Sequence and summary
  // ==============================

  initial begin
    pipeline_reset <= 1'b1;
    drive_idle();
    checks = 0;
    errors = 0;
    timeouts = 0;
    void'($urandom(38172));
    reset_behaviour();
    load_use_bubbles();
    multiply_divide_stalls();
    csr_and_mmio_stalls();
    redirect_flushes();
    valid_strobe_timing();
    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule : tb_hazard_resolution_unit

`default_nettype wire

// File: source/hazard_resolution_unit.sv
// Integer-only hazard control; trap and MRET must not depend on o_pipeline_ctrl.stall
`default_nettype none

module hazard_resolution_unit (
  input  wire logic                       i_clk,
  input  wire logic                       i_pipeline_reset,
  input  wire hazard_pkg::pd_sources_t    i_pd_sources,
  input  wire hazard_pkg::id_ex_info_t    i_id_ex,
  input  wire hazard_pkg::ex_ma_info_t    i_ex_ma,
  input  wire hazard_pkg::ex_comb_t       i_ex_comb,
  input  wire hazard_pkg::cache_status_t  i_cache,
  input  wire logic                       i_trap_taken,
  input  wire logic                       i_mret_taken,
  input  wire logic                       i_stall_for_wfi,
  output hazard_pkg::pipeline_ctrl_t      o_pipeline_ctrl,
  output logic                            o_mmio_read_pulse,
  output logic                            o_rst_done,
  output logic                            o_vld,
  output logic                            o_pc_vld
);

  // ==============================
  // Reset and stall combine
  // ==============================

  logic pipeline_reset;
  logic pipeline_stall;
  logic pipeline_flush;

  // Individual stall sources
  logic multicycle_stall;
  logic csr_stall;
  logic load_use_detected;
  logic stall_for_load_use;
  logic mmio_stall;

  logic stall_sources;
  logic stall_sources_for_trap;

  // Registered flush and stall state
  logic stall_registered;
  logic trap_taken_registered;
  logic mret_taken_registered;

  // The cache clears its tags after reset and the pipeline waits for it
  assign pipeline_reset = i_pipeline_reset || i_cache.reset_in_progress;
  assign o_rst_done = !i_cache.reset_in_progress;

  assign stall_sources = multicycle_stall || stall_for_load_use || csr_stall ||
                         mmio_stall || i_stall_for_wfi;

  // The trap unit sees this level, which ignores trap and MRET and so cannot loop
  // A CSR in EX is flushed by the trap anyway, so its wait is left out
  assign stall_sources_for_trap = multicycle_stall || stall_for_load_use ||
                                  mmio_stall || i_stall_for_wfi;

  // A taken trap or MRET wins over every stall, which is how WFI wakes up
  assign pipeline_stall = stall_sources && !i_trap_taken && !i_mret_taken;

  // ==============================
  // Hazard blocks
  // ==============================

  execute_stall_unit u_execute_stall_unit (
    .i_clk              (i_clk),
    .i_pipeline_reset   (pipeline_reset),
    .i_id_ex            (i_id_ex),
    .i_ex_comb          (i_ex_comb),
    .o_multicycle_stall (multicycle_stall),
    .o_csr_stall        (csr_stall)
  );

  load_use_detector u_load_use_detector (
    .i_clk                (i_clk),
    .i_pipeline_reset     (pipeline_reset),
    .i_stall              (pipeline_stall),
    .i_flush              (pipeline_flush),
    .i_pd_sources         (i_pd_sources),
    .i_id_ex              (i_id_ex),
    .i_ex_ma              (i_ex_ma),
    .i_cache_hit_on_load  (i_cache.hit_on_load),
    .i_multicycle_stall   (multicycle_stall),
    .o_load_use_detected  (load_use_detected),
    .o_stall_for_load_use (stall_for_load_use)
  );

  mmio_load_guard u_mmio_load_guard (
    .i_clk             (i_clk),
    .i_pipeline_reset  (pipeline_reset),
    .i_stall           (pipeline_stall),
    .i_flush           (pipeline_flush),
    .i_ex_ma           (i_ex_ma),
    .o_mmio_stall      (mmio_stall),
    .o_mmio_read_pulse (o_mmio_read_pulse)
  );

  flush_control u_flush_control (
    .i_clk                   (i_clk),
    .i_pipeline_reset        (pipeline_reset),
    .i_stall                 (pipeline_stall),
    .i_branch_taken          (i_ex_comb.branch_taken),
    .i_trap_taken            (i_trap_taken),
    .i_mret_taken            (i_mret_taken),
    .o_flush                 (pipeline_flush),
    .o_stall_registered      (stall_registered),
    .o_trap_taken_registered (trap_taken_registered),
    .o_mret_taken_registered (mret_taken_registered)
  );

  valid_token_tracker #(
    .num_stages (hazard_pkg::NUM_PIPELINE_STAGES)
  ) u_valid_token_tracker (
    .i_clk            (i_clk),
    .i_pipeline_reset (pipeline_reset),
    .i_stall          (pipeline_stall),
    .o_vld            (o_vld),
    .o_pc_vld         (o_pc_vld)
  );

  // ==============================
  // Control bundle
  // ==============================

  assign o_pipeline_ctrl.reset = pipeline_reset;
  assign o_pipeline_ctrl.stall = pipeline_stall;
  assign o_pipeline_ctrl.flush = pipeline_flush;
  assign o_pipeline_ctrl.stall_registered = stall_registered;
  assign o_pipeline_ctrl.stall_for_load_use_hazard = stall_for_load_use;
  // Forwarding needs the raw hazard even while a divide hides the bubble
  assign o_pipeline_ctrl.load_use_hazard_detected = load_use_detected;
  assign o_pipeline_ctrl.stall_for_trap_check = stall_sources_for_trap;
  assign o_pipeline_ctrl.trap_taken_registered = trap_taken_registered;
  assign o_pipeline_ctrl.mret_taken_registered = mret_taken_registered;

endmodule : hazard_resolution_unit

`default_nettype wire

// File: source/valid_token_tracker.sv
// Strobes follow a token stream and not real instructions; num_stages must exceed the PC index
`default_nettype none

module valid_token_tracker #(
  parameter int unsigned num_stages = hazard_pkg::NUM_PIPELINE_STAGES
) (
  input  wire logic i_clk,
  input  wire logic i_pipeline_reset,
  input  wire logic i_stall,
  output logic      o_vld,
  output logic      o_pc_vld
);

  // ==============================
  // Token shift register
  // ==============================

  // Bit n set means a token has reached stage n
  logic [num_stages-1:0] token;

  // A one enters at IF each cycle the pipeline moves
  always_ff @(posedge i_clk) begin
    if (i_pipeline_reset) begin
      token <= '0;
    end else if (!i_stall) begin
      token <= {token[num_stages-2:0], 1'b1};
    end
  end

  // Retire strobe from the last stage
  assign o_vld = token[num_stages-1] && !i_stall;

  // PC strobe once the token is in ID
  assign o_pc_vld = token[hazard_pkg::PC_VALID_STAGE_INDEX] && !i_stall;

endmodule : valid_token_tracker

`default_nettype wire

// File: source/flush_control.sv
// Flush covers PD and ID only, two cycles per redirect, and it is always masked by stall
`default_nettype none

module flush_control (
  input  wire logic i_clk,
  input  wire logic i_pipeline_reset,
  input  wire logic i_stall,
  input  wire logic i_branch_taken,
  input  wire logic i_trap_taken,
  input  wire logic i_mret_taken,
  output logic      o_flush,
  output logic      o_stall_registered,
  output logic      o_trap_taken_registered,
  output logic      o_mret_taken_registered
);

  // ==============================
  // Redirect extension
  // ==============================

  // Second flush cycle for each redirect source
  logic branch_taken_registered;

  // A redirect held across a stall would flush the correct-path fetch
  // that arrives when the stall ends, so the copies drop during a stall
  always_ff @(posedge i_clk) begin
    if (i_pipeline_reset) begin
      branch_taken_registered <= 1'b0;
      o_trap_taken_registered <= 1'b0;
      o_mret_taken_registered <= 1'b0;
    end else if (i_stall) begin
      branch_taken_registered <= 1'b0;
      o_trap_taken_registered <= 1'b0;
      o_mret_taken_registered <= 1'b0;
    end else begin
      branch_taken_registered <= i_branch_taken;
      o_trap_taken_registered <= i_trap_taken;
      o_mret_taken_registered <= i_mret_taken;
    end
  end

  // Wrong-path instructions sit in PD and ID when EX resolves the redirect
  assign o_flush = (i_branch_taken || branch_taken_registered ||
                    i_trap_taken || o_trap_taken_registered ||
                    i_mret_taken || o_mret_taken_registered) &&
                   !i_stall;

  // ==============================
  // Registered stall
  // ==============================

  // Stages use this to replay data held during the stall
  // A flush cycle is never stalled, so this copy is already low after a flush
  always_ff @(posedge i_clk) begin
    if (i_pipeline_reset) begin
      o_stall_registered <= 1'b0;
    end else begin
      o_stall_registered <= i_stall;
    end
  end

endmodule : flush_control

`default_nettype wire

// File: source/mmio_load_guard.sv
// Covers loads and LR into one fixed I/O window; stores to the window are not held back here
`default_nettype none

module mmio_load_guard (
  input  wire logic                    i_clk,
  input  wire logic                    i_pipeline_reset,
  input  wire logic                    i_stall,
  input  wire logic                    i_flush,
  input  wire hazard_pkg::ex_ma_info_t i_ex_ma,
  output logic                         o_mmio_stall,
  output logic                         o_mmio_read_pulse
);

  // ==============================
  // Window decode
  // ==============================

  logic                    is_read;
  logic                    in_window;
  logic                    mmio_load_in_ma;
  hazard_pkg::mmio_count_t mmio_count;

  assign is_read = i_ex_ma.is_load || i_ex_ma.is_lr;

  // Half-open range, the end address itself is outside
  assign in_window =
      (i_ex_ma.data_memory_address >= hazard_pkg::MMIO_BASE_ADDR) &&
      (i_ex_ma.data_memory_address <
       (hazard_pkg::MMIO_BASE_ADDR + hazard_pkg::MMIO_SIZE_BYTES));

  assign mmio_load_in_ma = is_read && in_window;

  // ==============================
  // Bubble counter
  // ==============================

  // Hold the load in MA until the device has produced its data
  assign o_mmio_stall = mmio_load_in_ma && (mmio_count < hazard_pkg::MMIO_STALL_CYCLES);

  // Side effects such as a FIFO pop must fire once per load
  // so the pulse is tied to the first bubble only
  assign o_mmio_read_pulse = mmio_load_in_ma && (mmio_count == '0);

  // Any free-running cycle means the load has left MA, so start over
  always_ff @(posedge i_clk) begin
    if (i_pipeline_reset || i_flush) begin
      mmio_count <= '0;
    end else if (!i_stall) begin
      mmio_count <= '0;
    end else if (o_mmio_stall) begin
      mmio_count <= mmio_count + hazard_pkg::mmio_count_t'(1);
    end
  end

endmodule : mmio_load_guard

`default_nettype wire

// File: source/execute_stall_unit.sv
// Multiplier must raise its completion prediction one cycle ahead; divide latency comes from busy
`default_nettype none

module execute_stall_unit (
  input  wire logic                    i_clk,
  input  wire logic                    i_pipeline_reset,
  input  wire hazard_pkg::id_ex_info_t i_id_ex,
  input  wire hazard_pkg::ex_comb_t    i_ex_comb,
  output logic                         o_multicycle_stall,
  output logic                         o_csr_stall
);

  // ==============================
  // Multiply and divide
  // ==============================

  // Registered prediction from the multiplier
  // It lines up with the cycle the product becomes valid
  logic multiply_completing_reg;
  logic multiply_stall;
  logic divide_stall;

  // Marks that the CSR in EX has already spent its wait cycle
  logic csr_read_waiting;

  always_ff @(posedge i_clk) begin
    if (i_pipeline_reset) begin
      multiply_completing_reg <= 1'b0;
    end else begin
      multiply_completing_reg <= i_ex_comb.multiply_completing_next_cycle;
    end
  end

  // The stall releases one cycle after the prediction rises
  assign multiply_stall = i_id_ex.is_multiply && !multiply_completing_reg;

  // Divide busy may be left high by the divider, so gate it by the opcode in EX
  assign divide_stall = i_id_ex.is_divide && i_ex_comb.divide_busy;

  assign o_multicycle_stall = multiply_stall || divide_stall;

  // ==============================
  // CSR read wait
  // ==============================

  // CSR read data is registered inside the CSR file
  // The first cycle in EX waits for it, the second cycle uses it
  always_ff @(posedge i_clk) begin
    if (i_pipeline_reset) begin
      csr_read_waiting <= 1'b0;
    end else begin
      csr_read_waiting <= i_id_ex.is_csr && !csr_read_waiting;
    end
  end

  assign o_csr_stall = i_id_ex.is_csr && !csr_read_waiting;

endmodule : execute_stall_unit

`default_nettype wire

// File: source/load_use_detector.sv
// Integer loads only; the one-shot flag expects the load to sit in MA during its bubble cycle
`default_nettype none

module load_use_detector (
  input  wire logic                     i_clk,
  input  wire logic                     i_pipeline_reset,
  input  wire logic                     i_stall,
  input  wire logic                     i_flush,
  input  wire hazard_pkg::pd_sources_t  i_pd_sources,
  input  wire hazard_pkg::id_ex_info_t  i_id_ex,
  input  wire hazard_pkg::ex_ma_info_t  i_ex_ma,
  input  wire logic                     i_cache_hit_on_load,
  input  wire logic                     i_multicycle_stall,
  output logic                          o_load_use_detected,
  output logic                          o_stall_for_load_use
);

  // ==============================
  // Fast potential hazard
  // ==============================

  // Only pipeline registers feed this compare, so it settles early in the cycle
  logic dest_matches_source;
  logic potential_hazard;

  // Registered copies that the final decision is built from
  logic potential_hazard_reg;
  logic cache_hit_reg;

  // Set during the single bubble so a held hazard cannot stall twice
  logic load_use_seen;

  assign dest_matches_source =
      (i_id_ex.dest_reg == i_pd_sources.source_reg_1_early) ||
      (i_id_ex.dest_reg == i_pd_sources.source_reg_2_early);

  // x0 is hardwired to zero and never creates a dependency
  assign potential_hazard = i_id_ex.is_load &&
                            (i_id_ex.dest_reg != '0) &&
                            dest_matches_source;

  // ==============================
  // Registered hit path
  // ==============================

  // The cache hit comes through forwarding, address add and tag compare
  // Ending it at a flop keeps that path out of the stall logic
  always_ff @(posedge i_clk) begin
    if (i_pipeline_reset || i_flush) begin
      potential_hazard_reg <= 1'b0;
      cache_hit_reg <= 1'b0;
    end else if (!i_stall) begin
      potential_hazard_reg <= potential_hazard;
      cache_hit_reg <= i_cache_hit_on_load;
    end
  end

  // A hit returns data in time for forwarding, a miss does not
  assign o_load_use_detected = potential_hazard_reg && !cache_hit_reg && !load_use_seen;

  // Multiply and divide stalls already hold the pipeline and take priority
  assign o_stall_for_load_use = o_load_use_detected && !i_multicycle_stall;

  // The flag updates on free-running cycles and on the load-use bubble itself
  // By the bubble the load has moved on to MA, which arms the flag for one cycle
  always_ff @(posedge i_clk) begin
    if (i_pipeline_reset) begin
      load_use_seen <= 1'b0;
    end else if (!i_stall || o_stall_for_load_use) begin
      load_use_seen <= i_ex_ma.is_load && o_stall_for_load_use;
    end
  end

endmodule : load_use_detector

`default_nettype wire

// File: source/hazard_pkg.sv
// Integer-only six-stage core; the MMIO window is fixed at build time and the counter fits two bubbles
`default_nettype none

package hazard_pkg;

  // ==============================
  // Pipeline geometry
  // ==============================

  // IF, PD, ID, EX, MA and WB
  localparam int unsigned NUM_PIPELINE_STAGES = 6;

  // Token bit that marks a valid PC once an instruction sits in ID
  localparam int unsigned PC_VALID_STAGE_INDEX = 2;

  // Integer register file has 32 entries
  localparam int unsigned REG_IDX_W = 5;

  // Data address width
  localparam int unsigned XLEN = 32;

  // ==============================
  // Memory-mapped I/O window
  // ==============================

  // Reads inside this range have side effects such as a UART RX pop
  localparam logic [XLEN-1:0] MMIO_BASE_ADDR = 32'h4000_0000;
  localparam logic [XLEN-1:0] MMIO_SIZE_BYTES = 32'h0000_0028;

  // The bubble counter must be able to hold MMIO_STALL_CYCLES
  localparam int unsigned MMIO_CNT_W = 2;

  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [MMIO_CNT_W-1:0] mmio_count_t;

  // Number of bubbles inserted for one side-effecting load
  localparam mmio_count_t MMIO_STALL_CYCLES = 2'd2;

  // ==============================
  // Stage bundles
  // ==============================

  // Source indices decoded early in PD, ahead of the full ID decode
  typedef struct packed {
    reg_idx_t source_reg_1_early;
    reg_idx_t source_reg_2_early;
  } pd_sources_t;

  // Instruction currently held in EX
  typedef struct packed {
    logic     is_load;
    logic     is_multiply;
    logic     is_divide;
    logic     is_csr;
    reg_idx_t dest_reg;
  } id_ex_info_t;

  // Instruction currently held in MA
  typedef struct packed {
    logic            is_load;
    logic            is_lr;
    logic [XLEN-1:0] data_memory_address;
  } ex_ma_info_t;

  // Live execute signals, not registered at the stage boundary
  typedef struct packed {
    logic branch_taken;
    logic multiply_completing_next_cycle;
    logic divide_busy;
  } ex_comb_t;

  typedef struct packed {
    logic reset_in_progress;
    logic hit_on_load;
  } cache_status_t;

  // Control bundle broadcast to every pipeline stage
  typedef struct packed {
    logic reset;
    logic stall;
    logic flush;
    logic stall_registered;
    logic stall_for_load_use_hazard;
    logic load_use_hazard_detected;
    logic stall_for_trap_check;
    logic trap_taken_registered;
    logic mret_taken_registered;
  } pipeline_ctrl_t;

endpackage : hazard_pkg

`default_nettype wire
